// ==== src/aes_pkg.sv ====
package aes_pkg;

    // Number of AES-256 rounds after the initial key addition
    localparam int AES_ROUNDS = 14;

    // One key-schedule word or one state column
    typedef logic [31:0]  aes_word_t;
    // State or data block, FIPS-197 byte 0 in the top byte
    typedef logic [127:0] aes_block_t;
    // Cipher key, key word 0 in the top bits
    typedef logic [255:0] aes_key_t;
    // Round counter, 0 to 14
    typedef logic [3:0]   aes_round_t;

    // One encryption job as queued by the host
    typedef struct packed {
        aes_key_t   key;
        aes_block_t pt;
    } aes_job_t;

    // Forward S-box, entry 0 leftmost
    localparam logic [0:255][7:0] SBOX = {
        128'h637c777b_f26b6fc5_3001672b_fed7ab76,
        128'hca82c97d_fa5947f0_add4a2af_9ca472c0,
        128'hb7fd9326_363ff7cc_34a5e5f1_71d83115,
        128'h04c723c3_1896059a_071280e2_eb27b275,
        128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84,
        128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf,
        128'hd0efaafb_434d3385_45f9027f_503c9fa8,
        128'h51a3408f_929d38f5_bcb6da21_10fff3d2,
        128'hcd0c13ec_5f974417_c4a77e3d_645d1973,
        128'h60814fdc_222a9088_46eeb814_de5e0bdb,
        128'he0323a0a_4906245c_c2d3ac62_9195e479,
        128'he7c8376d_8dd54ea9_6c56f4ea_657aae08,
        128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a,
        128'h703eb566_4803f60e_613557b9_86c11d9e,
        128'he1f89811_69d98e94_9b1e87e9_ce5528df,
        128'h8ca1890d_bfe64268_41992d0f_b054bb16
    };

    // Byte substitution through the S-box table
    function automatic logic [7:0] sub_byte(input logic [7:0] b);
        return SBOX[b];
    endfunction

    // SubWord of the key schedule, four independent lookups
    function automatic aes_word_t sub_word(input aes_word_t w);
        return {sub_byte(w[31:24]), sub_byte(w[23:16]), sub_byte(w[15:8]), sub_byte(w[7:0])};
    endfunction

    // Multiply by x in GF(2^8)
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // MixColumns on one column, top byte is row 0
    function automatic aes_word_t mix_column(input aes_word_t col);
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        // Rows of the circulant matrix 02 03 01 01
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

    // Round constant for key-schedule step idx, 1 to 7 for AES-256
    function automatic logic [7:0] rcon(input logic [2:0] idx);
        case (idx)
            3'd1:    return 8'h01;
            3'd2:    return 8'h02;
            3'd3:    return 8'h04;
            3'd4:    return 8'h08;
            3'd5:    return 8'h10;
            3'd6:    return 8'h20;
            3'd7:    return 8'h40;
            default: return 8'h00;
        endcase
    endfunction

endpackage

// ==== src/axil_pkg.sv ====
package axil_pkg;

    localparam int AXIL_ADDR_W = 8;
    localparam int AXIL_DATA_W = 32;

    typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [AXIL_DATA_W-1:0] axil_data_t;

    // Host-driven AXI4-Lite signals
    typedef struct packed {
        axil_addr_t               aw_addr;
        logic                     aw_valid;
        axil_data_t               w_data;
        logic [AXIL_DATA_W/8-1:0] w_strb;
        logic                     w_valid;
        logic                     b_ready;
        axil_addr_t               ar_addr;
        logic                     ar_valid;
        logic                     r_ready;
    } axil_req_t;

    // Slave-driven AXI4-Lite signals
    typedef struct packed {
        logic       aw_ready;
        logic       w_ready;
        logic [1:0] b_resp;
        logic       b_valid;
        logic       ar_ready;
        axil_data_t r_data;
        logic [1:0] r_resp;
        logic       r_valid;
    } axil_rsp_t;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Key words, word 0 most significant
    localparam axil_addr_t ADDR_KEY0 = 8'h00;
    localparam axil_addr_t ADDR_KEY1 = 8'h04;
    localparam axil_addr_t ADDR_KEY2 = 8'h08;
    localparam axil_addr_t ADDR_KEY3 = 8'h0c;
    localparam axil_addr_t ADDR_KEY4 = 8'h10;
    localparam axil_addr_t ADDR_KEY5 = 8'h14;
    localparam axil_addr_t ADDR_KEY6 = 8'h18;
    localparam axil_addr_t ADDR_KEY7 = 8'h1c;
    // Plaintext words
    localparam axil_addr_t ADDR_PT0  = 8'h20;
    localparam axil_addr_t ADDR_PT1  = 8'h24;
    localparam axil_addr_t ADDR_PT2  = 8'h28;
    localparam axil_addr_t ADDR_PT3  = 8'h2c;
    localparam axil_addr_t ADDR_CTRL   = 8'h30;
    localparam axil_addr_t ADDR_STATUS = 8'h34;
    // Result words
    localparam axil_addr_t ADDR_RES0 = 8'h40;
    localparam axil_addr_t ADDR_RES1 = 8'h44;
    localparam axil_addr_t ADDR_RES2 = 8'h48;
    localparam axil_addr_t ADDR_RES3 = 8'h4c;

    // CTRL bit positions
    localparam int CTRL_START   = 0;
    localparam int CTRL_RELEASE = 1;
    localparam int CTRL_CLR_OVF = 2;

    // STATUS bit positions
    localparam int STAT_RES_VALID = 0;
    localparam int STAT_JOB_FULL  = 1;
    localparam int STAT_BUSY      = 2;
    localparam int STAT_OVERFLOW  = 3;

endpackage

// ==== src/aes_axil_regs.sv ====
`timescale 1ns/1ps

module aes_axil_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  axil_pkg::axil_req_t axil_req,
    output axil_pkg::axil_rsp_t axil_rsp,
    output logic                job_push,
    output aes_pkg::aes_job_t   job_in,
    input  logic                job_full,
    input  logic                engine_busy,
    input  logic                res_valid,
    input  aes_pkg::aes_block_t res_data,
    output logic                res_ready
);

    import aes_pkg::*;
    import axil_pkg::*;

    // Host-written staging registers
    aes_key_t   key_q;
    aes_block_t pt_q;
    // Finished block held for the host
    aes_block_t res_q;
    logic       res_full;
    logic       overflow;
    // Goes high one cycle after reset, keeps readies low until then
    logic       live;

    // Write and read response state
    logic       b_valid;
    logic [1:0] b_resp;
    logic       r_valid;
    logic [1:0] r_resp;
    axil_data_t r_data;

    logic       wr_acc;
    logic       rd_acc;
    logic       ar_ready;
    logic       wr_key;
    logic       wr_pt;
    logic       wr_ctrl;
    logic       wr_ok;
    logic       ctrl_cmd;
    logic       start;
    axil_data_t status;
    axil_data_t rd_data;
    logic       rd_ok;

    // Word-aligned address inside [lo, hi]
    function automatic logic in_range(input axil_addr_t a, input axil_addr_t lo,
                                      input axil_addr_t hi);
        return (a[1:0] == 2'b00) && (a >= lo) && (a <= hi);
    endfunction

    // AW and W are taken together, one write in flight
    assign wr_acc   = live && axil_req.aw_valid && axil_req.w_valid && !b_valid;
    assign ar_ready = live && !r_valid;
    assign rd_acc   = axil_req.ar_valid && ar_ready;

    // Write decode
    assign wr_key  = in_range(axil_req.aw_addr, ADDR_KEY0, ADDR_KEY7);
    assign wr_pt   = in_range(axil_req.aw_addr, ADDR_PT0, ADDR_PT3);
    assign wr_ctrl = axil_req.aw_addr == ADDR_CTRL;
    // STATUS and result words take writes without effect
    assign wr_ok   = wr_key || wr_pt || wr_ctrl || axil_req.aw_addr == ADDR_STATUS
                     || in_range(axil_req.aw_addr, ADDR_RES0, ADDR_RES3);

    // CTRL commands only act with strobe lane 0
    assign ctrl_cmd = wr_acc && wr_ctrl && axil_req.w_strb[0];
    assign start    = ctrl_cmd && axil_req.w_data[CTRL_START];
    // Start on a full buffer is dropped and flagged as overflow
    assign job_push = start && !job_full;
    assign job_in   = '{key: key_q, pt: pt_q};

    assign res_ready = live && !res_full;

    always_comb begin
        status                 = '0;
        status[STAT_RES_VALID] = res_full;
        status[STAT_JOB_FULL]  = job_full;
        status[STAT_BUSY]      = engine_busy;
        status[STAT_OVERFLOW]  = overflow;
    end

    // Read mux, write-only registers return zero
    always_comb begin
        rd_data = '0;
        rd_ok   = 1'b0;
        if (in_range(axil_req.ar_addr, ADDR_KEY0, ADDR_KEY7)
            || in_range(axil_req.ar_addr, ADDR_PT0, ADDR_PT3)
            || axil_req.ar_addr == ADDR_CTRL) begin
            rd_ok = 1'b1;
        end
        if (axil_req.ar_addr == ADDR_STATUS) begin
            rd_ok   = 1'b1;
            rd_data = status;
        end
        if (in_range(axil_req.ar_addr, ADDR_RES0, ADDR_RES3)) begin
            rd_ok   = 1'b1;
            // RES0 is the top word of the block
            rd_data = res_q[127 - 32*axil_req.ar_addr[3:2] -: 32];
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (wr_acc && wr_key) begin
            for (int b = 0; b < 4; b++) begin
                if (axil_req.w_strb[b]) begin
                    key_q[224 - 32*axil_req.aw_addr[4:2] + 8*b +: 8] <= axil_req.w_data[8*b +: 8];
                end
            end
        end
        if (wr_acc && wr_pt) begin
            for (int b = 0; b < 4; b++) begin
                if (axil_req.w_strb[b]) begin
                    pt_q[96 - 32*axil_req.aw_addr[3:2] + 8*b +: 8] <= axil_req.w_data[8*b +: 8];
                end
            end
        end
        if (res_valid && res_ready) begin
            res_q <= res_data;
        end
        if (wr_acc) begin
            b_resp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_acc) begin
            r_data <= rd_data;
            r_resp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            live     <= 1'b0;
            b_valid  <= 1'b0;
            r_valid  <= 1'b0;
            res_full <= 1'b0;
            overflow <= 1'b0;
        end else begin
            live <= 1'b1;
            if (wr_acc) begin
                b_valid <= 1'b1;
            end else if (axil_req.b_ready) begin
                b_valid <= 1'b0;
            end
            if (rd_acc) begin
                r_valid <= 1'b1;
            end else if (axil_req.r_ready) begin
                r_valid <= 1'b0;
            end
            // Sticky until cleared, a new overflow wins over the clear
            if (ctrl_cmd && axil_req.w_data[CTRL_CLR_OVF]) begin
                overflow <= 1'b0;
            end
            if (start && job_full) begin
                overflow <= 1'b1;
            end
            // Release frees the slot, capture fills it
            if (ctrl_cmd && axil_req.w_data[CTRL_RELEASE]) begin
                res_full <= 1'b0;
            end
            if (res_valid && res_ready) begin
                res_full <= 1'b1;
            end
        end
    end

    always_comb begin
        axil_rsp          = '0;
        axil_rsp.aw_ready = wr_acc;
        axil_rsp.w_ready  = wr_acc;
        axil_rsp.b_valid  = b_valid;
        axil_rsp.b_resp   = b_resp;
        axil_rsp.ar_ready = ar_ready;
        axil_rsp.r_valid  = r_valid;
        axil_rsp.r_data   = r_data;
        axil_rsp.r_resp   = r_resp;
    end

endmodule

// ==== src/aes_job_fifo.sv ====
`timescale 1ns/1ps

module aes_job_fifo (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              job_push,
    input  aes_pkg::aes_job_t job_in,
    output logic              job_full,
    output logic              job_valid,
    output aes_pkg::aes_job_t job_out,
    input  logic              job_ready
);

    import aes_pkg::*;

    // Two slots, so one-bit pointers
    aes_job_t   mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       pop;

    assign job_full  = count == 2'd2;
    // Output comes from storage only, no fall-through
    assign job_valid = count != 2'd0;
    assign job_out   = mem[rd_ptr];
    assign pop       = job_valid && job_ready;

    always_ff @(posedge clk) begin
        if (job_push) begin
            mem[wr_ptr] <= job_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (job_push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            // Push and pop together leave the count alone
            case ({job_push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== src/aes256_round_core.sv ====
`timescale 1ns/1ps

module aes256_round_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                job_valid,
    input  aes_pkg::aes_job_t   job_out,
    output logic                job_ready,
    output logic                busy,
    output logic                res_valid,
    output aes_pkg::aes_block_t res_data,
    input  logic                res_ready
);

    import aes_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ROUND,
        DONE
    } fsm_t;

    fsm_t       fsm;
    logic       live;
    logic       accept;
    // Running state block
    aes_block_t blk;
    aes_round_t round;
    // Eight schedule words, low half is the key of the current round
    aes_key_t   win;
    aes_word_t  temp;
    aes_block_t nxt;
    aes_block_t shifted;
    aes_block_t mixed;
    aes_block_t round_out;

    assign job_ready = live && fsm == IDLE;
    assign accept    = job_valid && job_ready;
    assign busy      = fsm != IDLE;
    assign res_valid = fsm == DONE;
    assign res_data  = blk;

    // Next four schedule words
    always_comb begin
        // Odd rounds land on a multiple of eight words, RotWord and Rcon apply
        if (round[0]) begin
            temp = sub_word({win[23:0], win[31:24]}) ^ {rcon(round[3:1] + 3'd1), 24'h0};
        end else begin
            temp = sub_word(win[31:0]);
        end
        nxt[127:96] = win[255:224] ^ temp;
        nxt[95:64]  = win[223:192] ^ nxt[127:96];
        nxt[63:32]  = win[191:160] ^ nxt[95:64];
        nxt[31:0]   = win[159:128] ^ nxt[63:32];
    end

    // One full round, byte r + 4c sits at row r of column c
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            // SubBytes and ShiftRows, row r rotates left by r
            for (int r = 0; r < 4; r++) begin
                shifted[127 - 8*(4*c + r) -: 8] =
                    sub_byte(blk[127 - 8*(4*((c + r) % 4) + r) -: 8]);
            end
            mixed[127 - 32*c -: 32] = mix_column(shifted[127 - 32*c -: 32]);
        end
        // Last round skips MixColumns
        round_out = ((round == AES_ROUNDS) ? shifted : mixed) ^ win[127:0];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fsm   <= IDLE;
            live  <= 1'b0;
            round <= '0;
        end else begin
            live <= 1'b1;
            case (fsm)
                IDLE: begin
                    if (accept) begin
                        fsm   <= ROUND;
                        round <= 4'd1;
                    end
                end
                ROUND: begin
                    if (round == AES_ROUNDS) begin
                        fsm <= DONE;
                    end else begin
                        round <= round + 4'd1;
                    end
                end
                // Stalls here until the register block takes the block
                DONE: begin
                    if (res_ready) begin
                        fsm <= IDLE;
                    end
                end
                default: fsm <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            // Initial AddRoundKey with key words 0 to 3
            blk <= job_out.pt ^ job_out.key[255:128];
            win <= job_out.key;
        end else if (fsm == ROUND) begin
            blk <= round_out;
            win <= {win[127:0], nxt};
        end
    end

endmodule

// ==== src/aes256_enc_top.sv ====
`timescale 1ns/1ps

module aes256_enc_top (
    input  logic                clk,
    input  logic                rst_n,
    input  axil_pkg::axil_req_t axil_req,
    output axil_pkg::axil_rsp_t axil_rsp
);

    import aes_pkg::*;

    // Register block to job buffer
    logic       job_push;
    aes_job_t   job_in;
    logic       job_full;
    // Job buffer to round engine
    logic       job_valid;
    aes_job_t   job_out;
    logic       job_ready;
    // Round engine back to register block
    logic       engine_busy;
    logic       res_valid;
    aes_block_t res_data;
    logic       res_ready;

    aes_axil_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp),
        .job_push    (job_push),
        .job_in      (job_in),
        .job_full    (job_full),
        .engine_busy (engine_busy),
        .res_valid   (res_valid),
        .res_data    (res_data),
        .res_ready   (res_ready)
    );

    aes_job_fifo u_job_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .job_push  (job_push),
        .job_in    (job_in),
        .job_full  (job_full),
        .job_valid (job_valid),
        .job_out   (job_out),
        .job_ready (job_ready)
    );

    aes256_round_core u_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .job_valid (job_valid),
        .job_out   (job_out),
        .job_ready (job_ready),
        .busy      (engine_busy),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_ready (res_ready)
    );

endmodule

// ==== dv/aes256_enc_tb.sv ====
`timescale 1ns/1ps

module aes256_enc_tb;

    import aes_pkg::*;
    import axil_pkg::*;

    // Handshake flags that the bus tasks wait on
    localparam int FLAG_AW = 0;
    localparam int FLAG_B  = 1;
    localparam int FLAG_AR = 2;
    localparam int FLAG_R  = 3;
    localparam int WAIT_LIMIT = 64;
    localparam int POLL_LIMIT = 40;
    // Address inside the map with no register behind it
    localparam axil_addr_t ADDR_HOLE = 8'h50;

    // FIPS-197 appendix C.3
    localparam aes_key_t FIPS_KEY =
        256'h00010203_04050607_08090a0b_0c0d0e0f_10111213_14151617_18191a1b_1c1d1e1f;
    localparam aes_block_t FIPS_PT = 128'h00112233_44556677_8899aabb_ccddeeff;
    localparam aes_block_t FIPS_CT = 128'h8ea2b7ca_516745bf_eafc4990_4b496089;
    // SP800-38A F.1.5 vectors for ECB AES-256
    localparam aes_key_t SP_KEY =
        256'h603deb10_15ca71be_2b73aef0_857d7781_1f352c07_3b6108d7_2d9810a3_0914dff4;
    localparam aes_block_t SP_PT1 = 128'h6bc1bee2_2e409f96_e93d7e11_7393172a;
    localparam aes_block_t SP_CT1 = 128'hf3eed1bd_b5d2a03c_064b5a7e_3db181f8;
    localparam aes_block_t SP_PT2 = 128'hae2d8a57_1e03ac9c_9eb76fac_45af8e51;
    localparam aes_block_t SP_CT2 = 128'h591ccb10_d410ed26_dc5ba74a_31362870;
    localparam aes_block_t SP_PT3 = 128'h30c81c46_a35ce411_e5fbc119_1a0a52ef;
    localparam aes_block_t SP_CT3 = 128'hb6ed21b9_9ca6f4f9_f153e7b1_beafed1d;
    localparam aes_block_t SP_PT4 = 128'hf69f2445_df4f9b17_ad2b417b_e66c3710;

    logic      clk;
    logic      rst_n;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    integer    seed;
    int        errors;
    int        errors_at_start;
    int        tests_passed;
    int        tests_failed;

    aes256_enc_top UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic rsp_flag(input int which);
        case (which)
            FLAG_AW: return axil_rsp.aw_ready;
            FLAG_B:  return axil_rsp.b_valid;
            FLAG_AR: return axil_rsp.ar_ready;
            default: return axil_rsp.r_valid;
        endcase
    endfunction

    // Idle 0 to 3 cycles before the next valid or ready
    task automatic random_delay();
        int d;
        d = $unsigned($random(seed)) % 4;
        repeat (d) @(posedge clk);
    endtask

    // Responses are sampled on the falling edge between driving edges
    task automatic wait_flag(input int which, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!rsp_flag(which) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!rsp_flag(which)) begin
            $display("timeout: no %s within %0d cycles", what, WAIT_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] act);
        $display("error %s expected %0h got %0h", name, exp, act);
        errors++;
    endtask

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              input logic [3:0] strb, output logic [1:0] resp);
        random_delay();
        @(posedge clk);
        // AW and W offered together
        axil_req.aw_addr  <= addr;
        axil_req.aw_valid <= 1'b1;
        axil_req.w_data   <= data;
        axil_req.w_strb   <= strb;
        axil_req.w_valid  <= 1'b1;
        wait_flag(FLAG_AW, "write address accept");
        // W is taken in the same cycle as AW
        if (axil_rsp.w_ready !== 1'b1) report_mismatch("w_ready", 1'b1, axil_rsp.w_ready);
        @(posedge clk);
        axil_req.aw_valid <= 1'b0;
        axil_req.w_valid  <= 1'b0;
        random_delay();
        @(posedge clk);
        axil_req.b_ready <= 1'b1;
        wait_flag(FLAG_B, "write response");
        resp = axil_rsp.b_resp;
        @(posedge clk);
        axil_req.b_ready <= 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                             output logic [1:0] resp);
        random_delay();
        @(posedge clk);
        axil_req.ar_addr  <= addr;
        axil_req.ar_valid <= 1'b1;
        wait_flag(FLAG_AR, "read address accept");
        @(posedge clk);
        axil_req.ar_valid <= 1'b0;
        random_delay();
        @(posedge clk);
        axil_req.r_ready <= 1'b1;
        wait_flag(FLAG_R, "read data");
        data = axil_rsp.r_data;
        resp = axil_rsp.r_resp;
        @(posedge clk);
        axil_req.r_ready <= 1'b0;
    endtask

    task automatic write_checked(input axil_addr_t addr, input axil_data_t data,
                                 input logic [3:0] strb);
        logic [1:0] resp;
        axil_write(addr, data, strb, resp);
        if (resp !== RESP_OKAY) report_mismatch("b_resp", RESP_OKAY, resp);
    endtask

    task automatic read_checked(input axil_addr_t addr, output axil_data_t data);
        logic [1:0] resp;
        axil_read(addr, data, resp);
        if (resp !== RESP_OKAY) report_mismatch("r_resp", RESP_OKAY, resp);
    endtask

    // Writes key words first to 7 where word 0 is the top of the key
    task automatic write_key(input aes_key_t key, input int first);
        for (int i = first; i < 8; i++) begin
            write_checked(axil_addr_t'(ADDR_KEY0 + 4*i), key[255 - 32*i -: 32], 4'hf);
        end
    endtask

    task automatic write_block(input aes_block_t pt);
        for (int i = 0; i < 4; i++) begin
            write_checked(axil_addr_t'(ADDR_PT0 + 4*i), pt[127 - 32*i -: 32], 4'hf);
        end
    endtask

    task automatic send_ctrl(input int bit_pos);
        write_checked(ADDR_CTRL, 32'h1 << bit_pos, 4'b0001);
    endtask

    task automatic poll_done();
        axil_data_t st;
        int n;
        n = 0;
        read_checked(ADDR_STATUS, st);
        while (!st[STAT_RES_VALID] && n < POLL_LIMIT) begin
            read_checked(ADDR_STATUS, st);
            n++;
        end
        if (!st[STAT_RES_VALID]) begin
            $display("timeout: result valid still low after %0d status reads", n);
            $display("RESULT: FAIL");
            $finish;
        end
    endtask

    // Reads all four result words and compares the block
    task automatic check_result(input aes_block_t exp);
        aes_block_t ct;
        axil_data_t w;
        for (int i = 0; i < 4; i++) begin
            read_checked(axil_addr_t'(ADDR_RES0 + 4*i), w);
            ct[127 - 32*i -: 32] = w;
        end
        if (ct !== exp) report_mismatch("result", exp, ct);
    endtask

    task automatic mark_test_start();
        errors_at_start = errors;
    endtask

    task automatic report_test(input string name);
        if (errors == errors_at_start) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", name, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    task automatic reset_map();
        axil_data_t d;
        logic [1:0] resp;
        mark_test_start();
        // Handshake outputs stay low in the first cycle out of reset
        @(negedge clk);
        if (axil_rsp.aw_ready !== 1'b0) report_mismatch("aw_ready", 1'b0, axil_rsp.aw_ready);
        if (axil_rsp.w_ready !== 1'b0) report_mismatch("w_ready", 1'b0, axil_rsp.w_ready);
        if (axil_rsp.b_valid !== 1'b0) report_mismatch("b_valid", 1'b0, axil_rsp.b_valid);
        if (axil_rsp.ar_ready !== 1'b0) report_mismatch("ar_ready", 1'b0, axil_rsp.ar_ready);
        if (axil_rsp.r_valid !== 1'b0) report_mismatch("r_valid", 1'b0, axil_rsp.r_valid);
        read_checked(ADDR_STATUS, d);
        if (d !== 32'h0) report_mismatch("status", 32'h0, d);
        axil_read(ADDR_HOLE, d, resp);
        if (resp !== RESP_SLVERR) report_mismatch("r_resp", RESP_SLVERR, resp);
        if (d !== 32'h0) report_mismatch("r_data", 32'h0, d);
        // Key registers never read back
        read_checked(ADDR_KEY3, d);
        if (d !== 32'h0) report_mismatch("r_data", 32'h0, d);
        axil_write(ADDR_HOLE, 32'hffff_ffff, 4'hf, resp);
        if (resp !== RESP_SLVERR) report_mismatch("b_resp", RESP_SLVERR, resp);
        report_test("reset and map");
    endtask

    task automatic fips_vector();
        axil_data_t st;
        mark_test_start();
        write_key(FIPS_KEY, 0);
        write_block(FIPS_PT);
        send_ctrl(CTRL_START);
        poll_done();
        check_result(FIPS_CT);
        send_ctrl(CTRL_RELEASE);
        read_checked(ADDR_STATUS, st);
        if (st[STAT_RES_VALID] !== 1'b0) report_mismatch("status[0]", 1'b0, st[STAT_RES_VALID]);
        report_test("FIPS-197 vector");
    endtask

    task automatic byte_strobes();
        mark_test_start();
        // Each half carries junk in the lanes that stay disabled
        write_checked(ADDR_KEY0, {16'hdead, SP_KEY[239:224]}, 4'b0011);
        write_checked(ADDR_KEY0, {SP_KEY[255:240], 16'hbeef}, 4'b1100);
        write_key(SP_KEY, 1);
        write_block(SP_PT1);
        send_ctrl(CTRL_START);
        poll_done();
        check_result(SP_CT1);
        send_ctrl(CTRL_RELEASE);
        report_test("byte strobes");
    endtask

    task automatic job_queueing();
        mark_test_start();
        write_block(SP_PT1);
        send_ctrl(CTRL_START);
        // First job already holds its own copy of the block
        write_block(SP_PT2);
        send_ctrl(CTRL_START);
        poll_done();
        check_result(SP_CT1);
        send_ctrl(CTRL_RELEASE);
        poll_done();
        check_result(SP_CT2);
        // Second result stays held and stalls the engine in the next test
        report_test("queueing");
    endtask

    task automatic overflow_recovery();
        axil_data_t st;
        mark_test_start();
        write_block(SP_PT1);
        send_ctrl(CTRL_START);
        write_block(SP_PT2);
        send_ctrl(CTRL_START);
        write_block(SP_PT3);
        send_ctrl(CTRL_START);
        // Engine and both buffer slots are taken so this start is dropped
        write_block(SP_PT4);
        send_ctrl(CTRL_START);
        read_checked(ADDR_STATUS, st);
        if (st !== 32'hf) report_mismatch("status", 32'hf, st);
        send_ctrl(CTRL_CLR_OVF);
        read_checked(ADDR_STATUS, st);
        if (st !== 32'h7) report_mismatch("status", 32'h7, st);
        // Drop the result left over from queueing
        send_ctrl(CTRL_RELEASE);
        poll_done();
        check_result(SP_CT1);
        send_ctrl(CTRL_RELEASE);
        poll_done();
        check_result(SP_CT2);
        send_ctrl(CTRL_RELEASE);
        poll_done();
        check_result(SP_CT3);
        send_ctrl(CTRL_RELEASE);
        // Nothing left anywhere
        read_checked(ADDR_STATUS, st);
        if (st !== 32'h0) report_mismatch("status", 32'h0, st);
        report_test("overflow");
    endtask

    initial begin
        seed         = 32'hb02d_18d7;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        axil_req     = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        reset_map();
        fips_vector();
        byte_strobes();
        job_queueing();
        overflow_recovery();
        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
src/aes_pkg.sv
src/axil_pkg.sv
src/aes_axil_regs.sv
src/aes_job_fifo.sv
src/aes256_round_core.sv
src/aes256_enc_top.sv
dv/aes256_enc_tb.sv

// ==== Bender.yml ====
package:
  name: aes256_enc

sources:
  # Design sources, packages first
  - files:
      - src/aes_pkg.sv
      - src/axil_pkg.sv
      - src/aes_axil_regs.sv
      - src/aes_job_fifo.sv
      - src/aes256_round_core.sv
      - src/aes256_enc_top.sv

  # Testbench
  - target: test
    files:
      - dv/aes256_enc_tb.sv
